// ==== Bender.yml ====
package:
  name: sb_endpoint

sources:
  - files:
      - hw/sb_pkg.sv
      - hw/sb_ingress_arbiter.sv
      - hw/sb_header_decoder.sv
      - hw/sb_reg_target.sv
      - hw/sb_completion_tx.sv
      - hw/sb_endpoint_top.sv
  - target: test
    files:
      - testbench/sb_endpoint_properties.sv
      - testbench/sb_endpoint_tb.sv

// ==== hw/sb_completion_tx.sv ====
`timescale 1ns/100ps

module sb_completion_tx import sb_pkg::*; (
    input  logic                    side_clk,
    input  logic                    side_rst_b,
    input  logic                    cmp_valid,
    input  logic [sb_flit_bits-1:0] cmp_dst,
    input  sb_opcode_e              cmp_opcode,
    input  logic [sb_flit_bits-1:0] cmp_tag,
    input  logic [sb_flit_bits-1:0] cmp_data,
    input  logic                    cmp_has_data,
    output logic                    cmp_ready,
    output logic                    egress_valid,
    output logic [sb_flit_bits-1:0] egress_flit,
    output logic                    egress_eom,
    input  logic                    egress_ready
);

    // Index of the flit currently presented on egress
    logic [sb_tx_cnt_bits-1:0] flit_cnt;

    // Latched copy of the completion being sent
    logic [sb_flit_bits-1:0] tx_dst;
    sb_opcode_e              tx_opcode;
    logic [sb_flit_bits-1:0] tx_tag;
    logic [sb_flit_bits-1:0] tx_data;
    logic                    tx_has_data;

    // Idle while nothing is on egress
    assign cmp_ready = !egress_valid;

    // Data completions end on flit five, the rest on the tag flit
    assign egress_eom = egress_valid &&
                        (flit_cnt == (tx_has_data ? sb_tx_cnt_bits'(sb_hdr_flits)
                                                  : sb_tx_cnt_bits'(sb_hdr_flits - 1)));

    // Completion goes back to the requester, with our id as source
    always_comb begin
        case (flit_cnt)
            3'd0: egress_flit = tx_dst;
            3'd1: egress_flit = sb_my_id;
            3'd2: egress_flit = tx_opcode;
            3'd3: egress_flit = tx_tag;
            default: egress_flit = tx_data;
        endcase
    end

    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            egress_valid <= 1'b0;
            flit_cnt     <= '0;
        end else if (cmp_valid && cmp_ready) begin
            egress_valid <= 1'b1;
            flit_cnt     <= '0;
        end else if (egress_valid && egress_ready) begin
            if (egress_eom) begin
                egress_valid <= 1'b0;
                flit_cnt     <= '0;
            end else begin
                flit_cnt <= flit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge side_clk) begin
        if (cmp_valid && cmp_ready) begin
            tx_dst      <= cmp_dst;
            tx_opcode   <= cmp_opcode;
            tx_tag      <= cmp_tag;
            tx_data     <= cmp_data;
            tx_has_data <= cmp_has_data;
        end
    end

endmodule

// ==== hw/sb_endpoint_top.sv ====
`timescale 1ns/100ps

module sb_endpoint_top import sb_pkg::*; (
    input  logic                                       side_clk,
    input  logic                                       side_rst_b,
    input  logic [sb_num_ports-1:0]                    port_valid,
    input  logic [sb_num_ports-1:0][sb_flit_bits-1:0]  port_flit,
    input  logic [sb_num_ports-1:0]                    port_eom,
    output logic [sb_num_ports-1:0]                    port_ready,
    output logic                                       egress_valid,
    output logic [sb_flit_bits-1:0]                    egress_flit,
    output logic                                       egress_eom,
    input  logic                                       egress_ready
);

    // Arbitrated message stream into the target
    logic                    in_valid;
    logic                    in_ready;
    logic [sb_flit_bits-1:0] in_flit;
    logic                    in_eom;
    // Granted port, watched by the bound checks
    logic [sb_port_bits-1:0] in_port;

    // Header fields from the decoder
    logic                    hdr_valid;
    logic [sb_flit_bits-1:0] dst_id;
    logic [sb_flit_bits-1:0] src_id;
    logic [sb_flit_bits-1:0] opcode;
    logic [sb_flit_bits-1:0] tag;
    logic                    last_byte;

    // Completion hand-over
    logic                    cmp_valid;
    logic                    cmp_ready;
    logic [sb_flit_bits-1:0] cmp_dst;
    sb_opcode_e              cmp_opcode;
    logic [sb_flit_bits-1:0] cmp_tag;
    logic [sb_flit_bits-1:0] cmp_data;
    logic                    cmp_has_data;

    sb_ingress_arbiter sb_ingress_arbiter_inst (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .port_valid (port_valid),
        .port_flit  (port_flit),
        .port_eom   (port_eom),
        .port_ready (port_ready),
        .in_valid   (in_valid),
        .in_flit    (in_flit),
        .in_eom     (in_eom),
        .in_port    (in_port),
        .in_ready   (in_ready)
    );

    sb_header_decoder sb_header_decoder_inst (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .hdr_valid  (hdr_valid),
        .data       (in_flit),
        .dst_id     (dst_id),
        .src_id     (src_id),
        .opcode     (opcode),
        .tag        (tag),
        .last_byte  (last_byte)
    );

    sb_reg_target sb_reg_target_inst (
        .side_clk     (side_clk),
        .side_rst_b   (side_rst_b),
        .in_valid     (in_valid),
        .in_flit      (in_flit),
        .in_eom       (in_eom),
        .in_ready     (in_ready),
        .hdr_valid    (hdr_valid),
        .dst_id       (dst_id),
        .src_id       (src_id),
        .opcode       (opcode),
        .tag          (tag),
        .last_byte    (last_byte),
        .cmp_valid    (cmp_valid),
        .cmp_ready    (cmp_ready),
        .cmp_dst      (cmp_dst),
        .cmp_opcode   (cmp_opcode),
        .cmp_tag      (cmp_tag),
        .cmp_data     (cmp_data),
        .cmp_has_data (cmp_has_data)
    );

    sb_completion_tx sb_completion_tx_inst (
        .side_clk     (side_clk),
        .side_rst_b   (side_rst_b),
        .cmp_valid    (cmp_valid),
        .cmp_dst      (cmp_dst),
        .cmp_opcode   (cmp_opcode),
        .cmp_tag      (cmp_tag),
        .cmp_data     (cmp_data),
        .cmp_has_data (cmp_has_data),
        .cmp_ready    (cmp_ready),
        .egress_valid (egress_valid),
        .egress_flit  (egress_flit),
        .egress_eom   (egress_eom),
        .egress_ready (egress_ready)
    );

endmodule

// ==== hw/sb_header_decoder.sv ====
`timescale 1ns/100ps

module sb_header_decoder import sb_pkg::*; (
    input  logic                    side_clk,
    input  logic                    side_rst_b,
    input  logic                    hdr_valid,
    input  logic [sb_flit_bits-1:0] data,
    output logic [sb_flit_bits-1:0] dst_id,
    output logic [sb_flit_bits-1:0] src_id,
    output logic [sb_flit_bits-1:0] opcode,
    output logic [sb_flit_bits-1:0] tag,
    output logic                    last_byte
);

    // Position of the next header flit within the header
    logic [sb_hdr_cnt_bits-1:0] byte_count;

    // The fourth flit closes the header, only while it is accepted
    assign last_byte = hdr_valid &&
                       (byte_count == sb_hdr_cnt_bits'(sb_hdr_flits - 1));

    // Counter steps per accepted header flit and wraps after the tag
    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            byte_count <= '0;
        end else if (last_byte) begin
            byte_count <= '0;
        end else if (hdr_valid) begin
            byte_count <= byte_count + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Field capture
    // ----------------------------------------------------------------------

    // The counter value picks which field takes the flit
    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            dst_id <= '0;
            src_id <= '0;
            opcode <= '0;
            tag    <= '0;
        end else if (hdr_valid) begin
            case (byte_count)
                2'd0: dst_id <= data;
                2'd1: src_id <= data;
                2'd2: opcode <= data;
                default: tag <= data;
            endcase
        end
    end

endmodule

// ==== hw/sb_ingress_arbiter.sv ====
`timescale 1ns/100ps

module sb_ingress_arbiter import sb_pkg::*; (
    input  logic                                       side_clk,
    input  logic                                       side_rst_b,
    input  logic [sb_num_ports-1:0]                    port_valid,
    input  logic [sb_num_ports-1:0][sb_flit_bits-1:0]  port_flit,
    input  logic [sb_num_ports-1:0]                    port_eom,
    output logic [sb_num_ports-1:0]                    port_ready,
    output logic                                       in_valid,
    output logic [sb_flit_bits-1:0]                    in_flit,
    output logic                                       in_eom,
    output logic [sb_port_bits-1:0]                    in_port,
    input  logic                                       in_ready
);

    // Port that gets first look at the next message boundary
    logic [sb_port_bits-1:0] prio_q;
    // Set between the first and the eom flit of a message
    logic                    msg_open_q;
    // Port that owns the open message
    logic [sb_port_bits-1:0] owner_q;

    logic [sb_port_bits-1:0] idx;
    logic [sb_port_bits-1:0] pick;
    logic                    pick_found;
    logic [sb_port_bits-1:0] grant;
    logic                    grant_live;

    // Search from the favored port onward, walking backwards so that the
    // last hit is the one closest to prio_q
    always_comb begin
        pick = prio_q;
        pick_found = 1'b0;
        idx = prio_q;
        for (int i = sb_num_ports - 1; i >= 0; i--) begin
            idx = sb_port_bits'((int'(prio_q) + i) % sb_num_ports);
            if (port_valid[idx]) begin
                pick = idx;
                pick_found = 1'b1;
            end
        end
    end

    // Once a message is open the owner keeps the link until its eom flit
    assign grant      = msg_open_q ? owner_q : pick;
    assign grant_live = msg_open_q | pick_found;

    assign in_valid = grant_live & port_valid[grant];
    assign in_flit  = port_flit[grant];
    assign in_eom   = port_eom[grant];
    assign in_port  = grant;

    // Ready goes back to the granted port only
    always_comb begin
        port_ready = '0;
        if (grant_live) begin
            port_ready[grant] = in_ready;
        end
    end

    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            prio_q     <= '0;
            msg_open_q <= 1'b0;
            owner_q    <= '0;
        end else if (in_valid && in_ready) begin
            if (in_eom) begin
                // Message done, the next port in turn is favored
                msg_open_q <= 1'b0;
                prio_q     <= (grant == sb_port_bits'(sb_num_ports - 1)) ? '0 : grant + 1'b1;
            end else begin
                msg_open_q <= 1'b1;
                owner_q    <= grant;
            end
        end
    end

endmodule

// ==== hw/sb_pkg.sv ====
package sb_pkg;

    // ----------------------------------------------------------------------
    // Link geometry
    // ----------------------------------------------------------------------

    // One flit is a single byte on the sideband link
    localparam int sb_flit_bits = 8;

    // Destination, source, opcode and tag make up the header
    localparam int sb_hdr_flits = 4;
    localparam int sb_hdr_cnt_bits = $clog2(sb_hdr_flits);

    // Two peer agents share the endpoint
    localparam int sb_num_ports = 2;
    localparam int sb_port_bits = $clog2(sb_num_ports);

    // Completions carry the header flits plus at most one data flit
    localparam int sb_tx_cnt_bits = $clog2(sb_hdr_flits + 1);

    // Port id this endpoint answers to
    localparam logic [sb_flit_bits-1:0] sb_my_id = 8'h42;

    // Register file size, addressed by the low bits of the address flit
    localparam int sb_reg_depth = 16;
    localparam int sb_addr_bits = $clog2(sb_reg_depth);

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------

    typedef enum logic [7:0] {
        op_reg_read  = 8'h00,
        op_reg_write = 8'h01,
        op_cmp       = 8'h20,
        op_cmpd      = 8'h21,
        op_cmp_ur    = 8'h22
    } sb_opcode_e;

    typedef enum logic [2:0] {
        st_hdr,
        st_addr,
        st_data,
        st_drop,
        st_exec,
        st_send
    } sb_tgt_state_e;

endpackage

// ==== hw/sb_reg_target.sv ====
`timescale 1ns/100ps

module sb_reg_target import sb_pkg::*; (
    input  logic                    side_clk,
    input  logic                    side_rst_b,
    input  logic                    in_valid,
    input  logic [sb_flit_bits-1:0] in_flit,
    input  logic                    in_eom,
    output logic                    in_ready,
    output logic                    hdr_valid,
    input  logic [sb_flit_bits-1:0] dst_id,
    input  logic [sb_flit_bits-1:0] src_id,
    input  logic [sb_flit_bits-1:0] opcode,
    input  logic [sb_flit_bits-1:0] tag,
    input  logic                    last_byte,
    output logic                    cmp_valid,
    input  logic                    cmp_ready,
    output logic [sb_flit_bits-1:0] cmp_dst,
    output sb_opcode_e              cmp_opcode,
    output logic [sb_flit_bits-1:0] cmp_tag,
    output logic [sb_flit_bits-1:0] cmp_data,
    output logic                    cmp_has_data
);

    sb_tgt_state_e state;

    logic [sb_addr_bits-1:0] addr_q;
    logic [sb_flit_bits-1:0] data_q;
    logic [sb_flit_bits-1:0] regs [sb_reg_depth];

    logic for_me;
    logic op_known;
    logic is_write;

    assign for_me   = (dst_id == sb_my_id);
    assign is_write = (opcode == op_reg_write);
    assign op_known = (opcode == op_reg_read) || is_write;

    // Intake runs one flit per cycle until the message has been consumed
    assign in_ready  = (state == st_hdr) || (state == st_addr) ||
                       (state == st_data) || (state == st_drop);
    assign hdr_valid = in_valid && (state == st_hdr);

    // ----------------------------------------------------------------------
    // Message state machine and completion fields
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk or negedge side_rst_b) begin
        if (!side_rst_b) begin
            state        <= st_hdr;
            cmp_valid    <= 1'b0;
            cmp_dst      <= '0;
            cmp_opcode   <= op_reg_read;
            cmp_tag      <= '0;
            cmp_data     <= '0;
            cmp_has_data <= 1'b0;
        end else begin
            case (state)
                st_hdr: begin
                    // Destination and opcode are both settled by the tag flit
                    if (last_byte) begin
                        state <= (for_me && op_known) ? st_addr : st_drop;
                    end
                end
                st_addr: begin
                    if (in_valid) begin
                        state <= in_eom ? st_exec : st_data;
                    end
                end
                st_data: begin
                    if (in_valid && in_eom) begin
                        state <= st_exec;
                    end
                end
                st_drop: begin
                    // Our own id here means an unsupported opcode
                    if (in_valid && in_eom) begin
                        state <= for_me ? st_exec : st_hdr;
                    end
                end
                st_exec: begin
                    cmp_valid <= 1'b1;
                    cmp_dst   <= src_id;
                    cmp_tag   <= tag;
                    state     <= st_send;
                    if (!op_known) begin
                        cmp_opcode   <= op_cmp_ur;
                        cmp_data     <= '0;
                        cmp_has_data <= 1'b0;
                    end else if (is_write) begin
                        cmp_opcode   <= op_cmp;
                        cmp_data     <= '0;
                        cmp_has_data <= 1'b0;
                    end else begin
                        cmp_opcode   <= op_cmpd;
                        cmp_data     <= regs[addr_q];
                        cmp_has_data <= 1'b1;
                    end
                end
                st_send: begin
                    // Intake stays closed until the transmitter takes it
                    if (cmp_ready) begin
                        cmp_valid <= 1'b0;
                        state     <= st_hdr;
                    end
                end
                default: state <= st_hdr;
            endcase
        end
    end

    // Address and write data captured from the message body
    always_ff @(posedge side_clk) begin
        if (in_valid && (state == st_addr)) begin
            addr_q <= in_flit[sb_addr_bits-1:0];
        end
        if (in_valid && (state == st_data)) begin
            data_q <= in_flit;
        end
    end

    // Register file write happens in the execute cycle
    always_ff @(posedge side_clk) begin
        if ((state == st_exec) && is_write) begin
            regs[addr_q] <= data_q;
        end
    end

endmodule

// ==== src.f ====
hw/sb_pkg.sv
hw/sb_ingress_arbiter.sv
hw/sb_header_decoder.sv
hw/sb_reg_target.sv
hw/sb_completion_tx.sv
hw/sb_endpoint_top.sv
testbench/sb_endpoint_properties.sv
testbench/sb_endpoint_tb.sv

// ==== testbench/sb_endpoint_properties.sv ====
`timescale 1ns/100ps

module sb_endpoint_properties import sb_pkg::*; (
    input logic                    side_clk,
    input logic                    side_rst_b,
    input logic [sb_num_ports-1:0] port_ready,
    input logic                    in_valid,
    input logic                    in_ready,
    input logic                    in_eom,
    input logic [sb_port_bits-1:0] in_port,
    input logic                    egress_valid,
    input logic [sb_flit_bits-1:0] egress_flit,
    input logic                    egress_eom,
    input logic                    egress_ready
);

    // Failure count, watched from the testbench top
    int unsigned error_count = 0;

    // ----------------------------------------------------------------------
    // Egress handshake
    // ----------------------------------------------------------------------

    // A stalled flit stays on the link unchanged
    egress_hold: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (egress_valid && !egress_ready) |=>
            (egress_valid && $stable(egress_flit) && $stable(egress_eom)))
    else begin
        error_count++;
        $error("egress flit or eom changed while the link was stalled");
    end

    // Nothing is on egress in the first cycle out of reset
    reset_idle: assert property (@(posedge side_clk)
        $rose(side_rst_b) |-> !egress_valid)
    else begin
        error_count++;
        $error("egress_valid was high right after reset release");
    end

    // ----------------------------------------------------------------------
    // Ingress arbitration
    // ----------------------------------------------------------------------

    one_ready: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        $onehot0(port_ready))
    else begin
        error_count++;
        $error("both ingress ports saw ready in the same cycle");
    end

    // The grant holds from one accepted flit to the next until eom
    grant_lock: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (in_valid && in_ready && !in_eom) |=> (in_port == $past(in_port)))
    else begin
        error_count++;
        $error("grant moved to another port in the middle of a message");
    end

endmodule

// ==== testbench/sb_endpoint_tb.sv ====
`timescale 1ns/100ps

module sb_endpoint_tb import sb_pkg::*; ();

    logic                                      side_clk;
    logic                                      side_rst_b;
    logic [sb_num_ports-1:0]                   port_valid;
    logic [sb_num_ports-1:0][sb_flit_bits-1:0] port_flit;
    logic [sb_num_ports-1:0]                   port_eom;
    logic [sb_num_ports-1:0]                   port_ready;
    logic                                      egress_valid;
    logic [sb_flit_bits-1:0]                   egress_flit;
    logic                                      egress_eom;
    logic                                      egress_ready;

    // Separate LFSR states keep stimulus and egress stalls independent
    logic [15:0] stim_lfsr;
    logic [15:0] bp_lfsr;
    logic        bp_on;

    // Reference register file and the completion flits still owed
    logic [7:0] ref_regs [sb_reg_depth];
    logic [7:0] exp_flit_q [$];
    logic       exp_eom_q [$];

    // Grant tracking for the round-robin check
    int   last_port;
    logic msg_open;

    // Random message mix, drawn up front for both ports
    logic [7:0] mix_op   [sb_num_ports][12];
    logic [7:0] mix_dst  [sb_num_ports][12];
    logic [7:0] mix_addr [sb_num_ports][12];
    logic [7:0] mix_data [sb_num_ports][12];
    logic [7:0] mix_tag  [sb_num_ports][12];
    logic [7:0] mix_gap  [sb_num_ports][12];

    sb_endpoint_top sb_endpoint_top_inst (
        .side_clk     (side_clk),
        .side_rst_b   (side_rst_b),
        .port_valid   (port_valid),
        .port_flit    (port_flit),
        .port_eom     (port_eom),
        .port_ready   (port_ready),
        .egress_valid (egress_valid),
        .egress_flit  (egress_flit),
        .egress_eom   (egress_eom),
        .egress_ready (egress_ready)
    );

    bind sb_endpoint_top sb_endpoint_properties sb_endpoint_properties_inst (.*);

    initial side_clk = 1'b0;
    always #4 side_clk = ~side_clk;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[6:0], stim_lfsr[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // Completion owed for a message, built from the endpoint rules
    task automatic expect_completion(input logic [7:0] dst, input logic [7:0] src,
                                     input logic [7:0] op, input logic [7:0] tag,
                                     input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] cmp_op;
        logic       has_data;
        if (dst == sb_my_id) begin
            has_data = (op == op_reg_read);
            if (op == op_reg_write) begin
                ref_regs[addr[sb_addr_bits-1:0]] = data;
                cmp_op = op_cmp;
            end else if (op == op_reg_read) begin
                cmp_op = op_cmpd;
            end else begin
                cmp_op = op_cmp_ur;
            end
            exp_flit_q.push_back(src);
            exp_flit_q.push_back(sb_my_id);
            exp_flit_q.push_back(cmp_op);
            exp_flit_q.push_back(tag);
            exp_eom_q.push_back(1'b0);
            exp_eom_q.push_back(1'b0);
            exp_eom_q.push_back(1'b0);
            exp_eom_q.push_back(!has_data);
            if (has_data) begin
                exp_flit_q.push_back(ref_regs[addr[sb_addr_bits-1:0]]);
                exp_eom_q.push_back(1'b1);
            end
        end
    endtask

    // Header, address, then data for everything except a read
    task automatic send_msg(input int p, input logic [7:0] dst, input logic [7:0] src,
                            input logic [7:0] op, input logic [7:0] tag,
                            input logic [7:0] addr, input logic [7:0] data, input int gap);
        logic [7:0] flits [6];
        int         n;
        int         wait_cycles;
        flits = '{dst, src, op, tag, addr, data};
        n = (op == op_reg_read) ? 5 : 6;
        repeat (gap) @(negedge side_clk);
        for (int i = 0; i < n; i++) begin
            port_valid[p] = 1'b1;
            port_flit[p]  = flits[i];
            port_eom[p]   = (i == n - 1);
            wait_cycles = 0;
            @(posedge side_clk);
            while (!port_ready[p]) begin
                if (wait_cycles == 500) begin
                    abort_run($sformatf("Port %0d flit %0d was never accepted", p, i));
                end else begin
                    wait_cycles++;
                    @(posedge side_clk);
                end
            end
            // Expectations are queued in the order the eom flits are accepted
            if (i == n - 1) begin
                expect_completion(dst, src, op, tag, addr, data);
            end
            @(negedge side_clk);
        end
        port_valid[p] = 1'b0;
        port_eom[p]   = 1'b0;
    endtask

    task automatic run_mix(input int p);
        for (int k = 0; k < 12; k++) begin
            send_msg(p, mix_dst[p][k], 8'h10 + 8'(p), mix_op[p][k], mix_tag[p][k],
                     mix_addr[p][k], mix_data[p][k], int'(mix_gap[p][k]));
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((exp_flit_q.size() != 0) || egress_valid) begin
            if (cycles == 2000) begin
                abort_run("Completions were still outstanding when the drain timed out");
            end else begin
                cycles++;
                @(negedge side_clk);
            end
        end
    endtask

    // Called at the falling edge right after the eom flit was taken
    task automatic check_latency();
        int edges;
        edges = 0;
        while (!egress_valid) begin
            if (edges == 20) begin
                abort_run("No completion appeared after the eom flit was accepted");
            end else begin
                @(negedge side_clk);
                edges++;
            end
        end
        assert (edges == 2) else
            abort_run($sformatf("Fail egress_valid latency 0x%h expected 0x%h", edges, 2));
    endtask

    // ----------------------------------------------------------------------
    // Monitors
    // ----------------------------------------------------------------------

    // Every accepted egress flit must match the head of the expected queue
    always @(posedge side_clk) begin
        logic [7:0] exp_flit;
        logic       exp_eom;
        if (side_rst_b && egress_valid && egress_ready) begin
            if (exp_flit_q.size() == 0) begin
                abort_run("An egress flit arrived while no completion was expected");
            end else begin
                exp_flit = exp_flit_q.pop_front();
                exp_eom  = exp_eom_q.pop_front();
                assert (egress_flit == exp_flit) else
                    abort_run($sformatf("Fail egress_flit 0x%h expected 0x%h",
                                        egress_flit, exp_flit));
                assert (egress_eom == exp_eom) else
                    abort_run($sformatf("Fail egress_eom 0x%h expected 0x%h",
                                        egress_eom, exp_eom));
            end
        end
    end

    // With both ports requesting, a new message goes to the other port
    always @(posedge side_clk) begin
        if (side_rst_b) begin
            for (int p = 0; p < sb_num_ports; p++) begin
                if (port_valid[p] && port_ready[p]) begin
                    if (!msg_open && (&port_valid)) begin
                        assert (p != last_port) else
                            abort_run($sformatf("Fail port_ready grant 0x%h expected 0x%h",
                                                p, 1 - last_port));
                    end
                    msg_open = !port_eom[p];
                    if (port_eom[p]) begin
                        last_port = p;
                    end
                end
            end
        end
    end

    always @(negedge side_clk) begin
        if (sb_endpoint_top_inst.sb_endpoint_properties_inst.error_count != 0) begin
            abort_run("A bound handshake assertion failed");
        end
    end

    // Egress stalls follow the LFSR only while back-pressure is enabled
    always @(negedge side_clk) begin
        if (bp_on) begin
            bp_lfsr = lfsr_step(bp_lfsr);
            egress_ready = bp_lfsr[0];
        end else begin
            egress_ready = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    initial begin
        logic [7:0] a;
        logic [7:0] d;
        logic [7:0] t;
        logic [7:0] sel;
        side_rst_b   = 1'b0;
        port_valid   = '0;
        port_flit    = '0;
        port_eom     = '0;
        egress_ready = 1'b0;
        bp_on        = 1'b0;
        stim_lfsr    = 16'd39;
        bp_lfsr      = 16'd39;
        last_port    = 1;
        msg_open     = 1'b0;
        repeat (16) @(negedge side_clk);
        side_rst_b = 1'b1;
        @(negedge side_clk);

        // Known contents everywhere before any read
        for (int i = 0; i < sb_reg_depth; i++) begin
            draw_bits(8, d);
            send_msg(0, sb_my_id, 8'h10, op_reg_write, 8'(i), 8'(i), d, 0);
        end

        // Write then read back from port 0
        draw_bits(4, a);
        draw_bits(8, d);
        draw_bits(8, t);
        send_msg(0, sb_my_id, 8'h10, op_reg_write, t, a, d, 0);
        send_msg(0, sb_my_id, 8'h10, op_reg_read, t + 8'd1, a, 8'h00, 1);
        wait_drained();

        // Idle egress and no stalls, so the latency is fixed
        draw_bits(8, t);
        send_msg(1, sb_my_id, 8'h11, op_reg_read, t, a, 8'h00, 0);
        check_latency();
        wait_drained();

        // Unsupported opcode must leave the register alone
        send_msg(0, sb_my_id, 8'h10, 8'h3c, t, a, ~d, 0);
        send_msg(0, sb_my_id, 8'h10, op_reg_read, t ^ 8'h5a, a, 8'h00, 0);

        // Foreign destination is swallowed, the next read still works
        send_msg(1, 8'h17, 8'h11, op_reg_write, t, a, ~d, 0);
        send_msg(1, sb_my_id, 8'h11, op_reg_read, t, a, 8'h00, 0);
        wait_drained();

        // Both ports at once, first with a free egress, then with stalls
        for (int r = 0; r < 2; r++) begin
            bp_on <= (r == 1);
            for (int p = 0; p < sb_num_ports; p++) begin
                for (int k = 0; k < 12; k++) begin
                    draw_bits(2, sel);
                    mix_op[p][k]  = (sel == 0) ? op_reg_read :
                                    (sel == 2) ? 8'h3c : op_reg_write;
                    mix_dst[p][k] = (sel == 3) ? 8'h17 : sb_my_id;
                    draw_bits(4, mix_addr[p][k]);
                    draw_bits(8, mix_data[p][k]);
                    draw_bits(8, mix_tag[p][k]);
                    draw_bits(2, mix_gap[p][k]);
                end
            end
            fork
                run_mix(0);
                run_mix(1);
            join
            wait_drained();
        end
        bp_on <= 1'b0;
        @(negedge side_clk);

        if (sb_endpoint_top_inst.sb_endpoint_properties_inst.error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("A bound handshake assertion failed near the end of the run");
        end
    end

endmodule
